/* Bender.yml */
package:
  name: monopix_periphery

export_include_dirs:
  - .

sources:
  - files:
      - monopixPkg.sv
      - confShiftReg.sv
      - bcidCounter.sv
      - hitCollector.sv
      - readoutArbiter.sv
      - monopixPeriphery.sv
  - target: test
    files:
      - monopixChecker.sv
      - monopixPeriphery_asserts.sv
      - monopixTb.sv

/* bcidCounter.sv */
`timescale 1ns/10ps
`include "monopix_params.svh"

module bcidCounter (
    input  logic                     ClkBx,
    input  logic                     reset_ff,
    input  logic                     resetBcid,
    output logic [`MP_BCID_BITS-1:0] bcidGray
);

    logic                     resetStage;   // Crossing reset delayed by one cycle
    logic [`MP_BCID_BITS-1:0] bcidBin;

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            resetStage <= 1'b0;
        end else begin
            resetStage <= resetBcid;
        end
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff || resetStage) begin
            bcidBin <= '0;
        end else begin
            bcidBin <= bcidBin + 1'b1;   // Wraps naturally
        end
    end

    assign bcidGray = (bcidBin >> 1) ^ bcidBin;

endmodule

/* confShiftReg.sv */
`timescale 1ns/10ps
`include "monopix_params.svh"

module confShiftReg import monopixPkg::*; (
    input  logic    ClkBx,
    input  logic    reset_ff,
    input  tConfCtl confCtl,
    output tConf    conf,
    output logic    confSo
);

    localparam int ConfBits = $bits(tConf);

    // Power-up image
    localparam tConf DefaultConf = '{
        enFlavor: `MP_DEF_EN_FLAVOR,
        enHitOr:  `MP_DEF_EN_HITOR,
        pulseSel: '0
    };

    logic [ConfBits-1:0] shiftReg;

    // Serial chain with the new bit entering at the LSB
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            shiftReg <= '0;
        end else if (confCtl.shiftEn) begin
            shiftReg <= {shiftReg[ConfBits-2:0], confCtl.si};
        end
    end

    // Applied image
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            conf <= DefaultConf;
        end else if (confCtl.defConf) begin
            conf <= DefaultConf;   // Default load wins over load
        end else if (confCtl.load) begin
            conf <= tConf'(shiftReg);   // Chain contents before this edge
        end
    end

    // Readback from the far end of the chain
    assign confSo = shiftReg[ConfBits-1];

endmodule

/* files.f */
+incdir+.
monopixPkg.sv
confShiftReg.sv
bcidCounter.sv
hitCollector.sv
readoutArbiter.sv
monopixPeriphery.sv
monopixChecker.sv
monopixPeriphery_asserts.sv
monopixTb.sv

/* hitCollector.sv */
`timescale 1ns/10ps
`include "monopix_params.svh"

module hitCollector import monopixPkg::*; (
    input  logic                           ClkBx,
    input  logic                           reset_ff,
    input  logic [$clog2(`MP_FLAVORS)-1:0] flavor,
    input  logic                           enable,
    input  logic                           enHitOr,
    input  logic [`MP_COLS-1:0]            pulseSel,
    input  logic [`MP_COLS-1:0]            hits,
    input  logic                           pulse,
    input  logic [`MP_BCID_BITS-1:0]       bcidGray,
    output tBusReq                         busReq,
    input  logic                           busAck,
    output logic                           hitOr
);

    localparam int ColW = $clog2(`MP_COLS);

    logic [`MP_COLS-1:0]      effHits;
    logic [`MP_COLS-1:0]      newHits;
    logic [`MP_COLS-1:0]      pending;
    logic [`MP_COLS-1:0]      remain;       // Pending after this cycle's ack
    logic [`MP_BCID_BITS-1:0] stamps [`MP_COLS];
    logic                     busy;         // Word on the bus
    logic [ColW-1:0]          selCol;
    logic [ColW-1:0]          nextCol;

    // Sensor hits plus charge injection
    assign effHits = hits | ({`MP_COLS{pulse}} & pulseSel);
    assign hitOr   = enHitOr & (|effHits);

    always_comb begin
        remain = pending;
        if (busy && busAck) begin
            remain[selCol] = 1'b0;
        end
        nextCol = '0;
        for (int c = `MP_COLS - 1; c >= 0; c--) begin
            if (remain[c]) begin
                nextCol = ColW'(c);   // Lowest pending column ends up here
            end
        end
    end

    // A hit on a column still pending is dropped
    assign newHits = enable ? (effHits & ~remain) : '0;

    always_ff @(posedge ClkBx) begin
        for (int c = 0; c < `MP_COLS; c++) begin
            if (newHits[c]) begin
                stamps[c] <= bcidGray;   // Stamp seen before the edge
            end
        end
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            pending <= '0;
            busy    <= 1'b0;
            selCol  <= '0;
        end else begin
            pending <= remain | newHits;
            if (!busy || busAck) begin
                busy   <= |remain;   // Chain straight into the next word
                selCol <= nextCol;
            end
        end
    end

    // Held stable until ack since selCol only moves on ack
    always_comb begin
        busReq.cyc        = busy;
        busReq.stb        = busy;
        busReq.dat.flavor = flavor;
        busReq.dat.col    = selCol;
        busReq.dat.bcid   = stamps[selCol];
    end

endmodule

/* monopixChecker.sv */
`timescale 1ns/10ps
`include "monopix_params.svh"

module monopixChecker import monopixPkg::*; (
    input  logic                                 ClkBx,
    input  logic                                 reset_ff,
    input  tConfCtl                              confCtl,
    input  logic                                 resetBcid,
    input  logic [`MP_FLAVORS-1:0][`MP_COLS-1:0] hits,
    input  logic                                 pulse,
    input  logic                                 busAck,
    input  logic                                 confSo,
    input  logic [`MP_FLAVORS-1:0]               hitOr,
    input  tBusReq                               busReq,
    input  logic                                 sectionDone,
    input  logic [127:0]                         sectionName,
    output int                                   errors,
    output int                                   words
);

    localparam int   ConfBits = $bits(tConf);
    localparam int   FlavW    = $clog2(`MP_FLAVORS);
    localparam int   ColW     = $clog2(`MP_COLS);
    localparam tConf DefConf  = '{`MP_DEF_EN_FLAVOR, `MP_DEF_EN_HITOR, '0};

    logic [ConfBits-1:0]      modelSr;
    tConf                     modelConf;
    logic [`MP_BCID_BITS-1:0] modelCnt;
    logic                     modelRst;    // Crossing reset stage
    tHitWord                  expQ [`MP_FLAVORS][$];
    int                       secErrors;

    task automatic countError();
        errors++;
        secErrors++;
    endtask

    initial begin
        errors    = 0;
        words     = 0;
        secErrors = 0;
    end

    always @(posedge ClkBx) begin
        logic [`MP_COLS-1:0]       eff;
        logic [`MP_FLAVORS-1:0]    expOr;
        logic [`MP_BCID_BITS-1:0]  stamp;
        tHitWord                   want;
        if (reset_ff) begin
            modelSr   = '0;
            modelConf = DefConf;
            modelCnt  = '0;
            modelRst  = 1'b0;
        end else begin
            if (confSo !== modelSr[ConfBits-1]) begin
                $display("FAILED at %0t: confSo %b, expected %b", $time, confSo,
                         modelSr[ConfBits-1]);
                countError();
            end
            // Word handed over at this edge
            if (busReq.cyc && busReq.stb && busAck) begin
                words++;
                if (expQ[busReq.dat.flavor].size() == 0) begin
                    $display("Flavour %0d sent a word at %0t but no hit was waiting",
                             busReq.dat.flavor, $time);
                    countError();
                end else begin
                    want = expQ[busReq.dat.flavor].pop_front();
                    if (busReq.dat !== want) begin
                        $display("FAILED at %0t: flavour %0d col %0d stamp %h, expected %0d %h",
                                 $time, busReq.dat.flavor, busReq.dat.col, busReq.dat.bcid,
                                 want.col, want.bcid);
                        countError();
                    end
                end
            end
            // Gray code of the modelled count
            stamp = modelCnt;
            for (int b = 0; b < `MP_BCID_BITS - 1; b++) begin
                stamp[b] = modelCnt[b] ^ modelCnt[b + 1];
            end
            // Capture with conf and count as they were before the edge
            for (int f = 0; f < `MP_FLAVORS; f++) begin
                eff      = hits[f] | ({`MP_COLS{pulse}} & modelConf.pulseSel[f]);
                expOr[f] = modelConf.enHitOr[f] & (|eff);
                for (int c = 0; c < `MP_COLS; c++) begin
                    if (modelConf.enFlavor[f] && eff[c]) begin
                        want.flavor = FlavW'(f);
                        want.col    = ColW'(c);
                        want.bcid   = stamp;
                        expQ[f].push_back(want);
                    end
                end
            end
            if (hitOr !== expOr) begin
                $display("FAILED at %0t: hitOr %b, expected %b", $time, hitOr, expOr);
                countError();
            end
            if (sectionDone) begin
                for (int f = 0; f < `MP_FLAVORS; f++) begin
                    if (expQ[f].size() != 0) begin
                        $display("Test %0s: %0d word(s) of flavour %0d never arrived",
                                 sectionName, expQ[f].size(), f);
                        errors    += expQ[f].size();
                        secErrors += expQ[f].size();
                        expQ[f].delete();
                    end
                end
                if (secErrors == 0) begin
                    $display("Test %0s: passed", sectionName);
                end else begin
                    $display("Test %0s: failed with %0d error(s)", sectionName, secErrors);
                end
                secErrors = 0;
            end
            modelCnt = modelRst ? '0 : modelCnt + 1'b1;
            modelRst = resetBcid;
            if (confCtl.defConf) begin
                modelConf = DefConf;
            end else if (confCtl.load) begin
                modelConf = tConf'(modelSr);
            end
            if (confCtl.shiftEn) begin
                modelSr = {modelSr[ConfBits-2:0], confCtl.si};
            end
        end
    end

endmodule

/* monopixPeriphery.sv */
`timescale 1ns/10ps
`include "monopix_params.svh"

module monopixPeriphery import monopixPkg::*; (
    input  logic                                  ClkBx,
    input  logic                                  reset_ff,
    input  tConfCtl                               confCtl,
    input  logic                                  resetBcid,
    input  logic [`MP_FLAVORS-1:0][`MP_COLS-1:0]  hits,
    input  logic                                  pulse,
    input  logic                                  busAck,
    output logic                                  confSo,
    output logic [`MP_FLAVORS-1:0]                hitOr,
    output tBusReq                                busReq
);

    tConf                     conf;
    logic [`MP_BCID_BITS-1:0] bcidGray;
    tBusReq [`MP_FLAVORS-1:0] collReq;
    logic [`MP_FLAVORS-1:0]   collAck;

    confShiftReg u_confShiftReg (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .confCtl  (confCtl),
        .conf     (conf),
        .confSo   (confSo)
    );

    bcidCounter u_bcidCounter (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .resetBcid (resetBcid),
        .bcidGray  (bcidGray)
    );

    // One readout per sensor flavour
    for (genvar g = 0; g < `MP_FLAVORS; g++) begin : gFlavor
        hitCollector u_hitCollector (
            .ClkBx    (ClkBx),
            .reset_ff (reset_ff),
            .flavor   ($clog2(`MP_FLAVORS)'(g)),
            .enable   (conf.enFlavor[g]),
            .enHitOr  (conf.enHitOr[g]),
            .pulseSel (conf.pulseSel[g]),
            .hits     (hits[g]),
            .pulse    (pulse),
            .bcidGray (bcidGray),
            .busReq   (collReq[g]),
            .busAck   (collAck[g]),
            .hitOr    (hitOr[g])
        );
    end

    readoutArbiter #(
        .PayloadT   (tHitWord),
        .NumMasters (`MP_FLAVORS)
    ) u_readoutArbiter (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .reqIn    (collReq),
        .ackOut   (collAck),
        .reqOut   (busReq),
        .ackIn    (busAck)
    );

endmodule

/* monopixPeriphery_asserts.sv */
`timescale 1ns/10ps

module arbiterAsserts #(
    parameter int NumMasters = 4,
    parameter int ReqW       = 12
) (
    input logic                  ClkBx,
    input logic                  reset_ff,
    input logic [ReqW-1:0]       reqOut,
    input logic                  ackIn,
    input logic [NumMasters-1:0] grantOh
);

    int              failures = 0;
    logic            stb;
    logic [ReqW-3:0] dat;

    assign stb = reqOut[ReqW-2];   // Below cyc at the top
    assign dat = reqOut[ReqW-3:0];

    datHeld: assert property (@(posedge ClkBx) disable iff (reset_ff)
        stb && !ackIn |=> stb && $stable(dat))
    else begin
        $error("Bus word changed while it waited for ack");
        failures++;
    end

    grantHeld: assert property (@(posedge ClkBx) disable iff (reset_ff)
        |grantOh && !ackIn |=> $stable(grantOh))
    else begin
        $error("Grant moved to another master before the word was acked");
        failures++;
    end

    ackNeedsStb: assert property (@(posedge ClkBx) disable iff (reset_ff) ackIn |-> stb)
    else begin
        $error("Ack seen with no strobe on the bus");
        failures++;
    end

endmodule

bind readoutArbiter arbiterAsserts #(
    .NumMasters (NumMasters),
    .ReqW       ($bits(reqOut))
) u_arbiterAsserts (
    .ClkBx    (ClkBx),
    .reset_ff (reset_ff),
    .reqOut   (reqOut),
    .ackIn    (ackIn),
    .grantOh  (grantOh)
);

/* monopixPkg.sv */
`include "monopix_params.svh"

package monopixPkg;

    // Applied configuration image with enFlavor at the MSB end
    typedef struct packed {
        logic [`MP_FLAVORS-1:0] enFlavor;
        logic [`MP_FLAVORS-1:0] enHitOr;
        logic [`MP_FLAVORS-1:0][`MP_COLS-1:0] pulseSel;   // Injection column select
    } tConf;

    // One hit as it leaves the chip
    typedef struct packed {
        logic [$clog2(`MP_FLAVORS)-1:0] flavor;
        logic [$clog2(`MP_COLS)-1:0] col;
        logic [`MP_BCID_BITS-1:0] bcid;   // Gray coded
    } tHitWord;

    // Serial configuration controls
    typedef struct packed {
        logic shiftEn;
        logic load;
        logic defConf;
        logic si;
    } tConfCtl;

    // Wishbone classic master side for writes only
    typedef struct packed {
        logic cyc;
        logic stb;
        tHitWord dat;
    } tBusReq;

endpackage

/* monopixTb.sv */
`timescale 1ns/10ps
`include "monopix_params.svh"

module monopixTb import monopixPkg::*; ();

    logic                                 ClkBx;
    logic                                 reset_ff;
    tConfCtl                              confCtl;
    logic                                 resetBcid;
    logic [`MP_FLAVORS-1:0][`MP_COLS-1:0] hits;
    logic                                 pulse;
    logic                                 busAck;
    logic                                 confSo;
    logic [`MP_FLAVORS-1:0]               hitOr;
    tBusReq                               busReq;
    logic                                 sectionDone;
    logic [127:0]                         sectionName;
    int                                   errors;
    int                                   words;

    byte          cmdOp [$];
    int           cmdA [$];
    int           cmdB [$];
    logic [127:0] cmdName [$];
    logic [31:0]  lfsr;
    int           cycles;
    int           limit;
    int           tests;
    int           ackWait;     // Cycles left before ack or -1 when not drawn

    monopixPeriphery u_monopixPeriphery (.*);
    monopixChecker u_monopixChecker (.*);

    initial ClkBx = 1'b0;
    always #4 ClkBx = ~ClkBx;

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Sink with a random ack delay of 0 to 3 cycles
    always @(negedge ClkBx) begin
        if (reset_ff || busAck) begin
            busAck  = 1'b0;   // Word taken at the last edge
            ackWait = -1;
        end else if (busReq.cyc && busReq.stb) begin
            if (ackWait < 0) begin
                ackWait = 0;
                repeat (2) begin
                    lfsr    = lfsrStep(lfsr);
                    ackWait = (ackWait << 1) | lfsr[0];
                end
            end
            if (ackWait == 0) begin
                busAck = 1'b1;
            end else begin
                ackWait--;
            end
        end
    end

    always @(posedge ClkBx) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, the trace did not finish", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic readTrace();
        int           fd;
        string        line;
        logic [63:0]  opText;
        logic [127:0] name;
        int           a;
        int           b;
        int           sumCycles;
        int           expWords;
        byte          op;
        sumCycles = 16;
        expWords  = 0;
        fd = $fopen("readoutTrace.txt", "r");
        if (fd == 0) begin
            $display("Could not open readoutTrace.txt, no tests to run");
        end else begin
            while ($fgets(line, fd) > 0) begin
                op   = line.getc(0);
                a    = 0;
                b    = 0;
                name = '0;
                if (op == "T") begin
                    void'($sscanf(line, "%s %s", opText, name));
                end else begin
                    void'($sscanf(line, "%s %h %h", opText, a, b));
                end
                if (op inside {"T", "C", "L", "D", "R", "H", "P", "I", "E"}) begin
                    cmdOp.push_back(op);
                    cmdA.push_back(a);
                    cmdB.push_back(b);
                    cmdName.push_back(name);
                    case (op)
                        "C": sumCycles += $bits(tConf);
                        "I": sumCycles += a;
                        "E": sumCycles += 5;
                        default: sumCycles += 1;
                    endcase
                    if (op == "H") begin
                        expWords += $countones(b);
                    end else if (op == "P") begin
                        expWords += `MP_FLAVORS * `MP_COLS;   // Upper bound
                    end
                end
            end
            $fclose(fd);
        end
        limit = sumCycles + 8 * expWords + 100;
    endtask

    task automatic runCommand(input int i);
        int quiet;
        case (cmdOp[i])
            "T": sectionName = cmdName[i];
            "C": begin
                for (int k = $bits(tConf) - 1; k >= 0; k--) begin   // MSB first
                    confCtl.shiftEn = 1'b1;
                    confCtl.si      = 1'(cmdA[i] >> k);
                    @(negedge ClkBx);
                end
                confCtl = '0;
            end
            "L": begin
                confCtl.load = 1'b1;
                @(negedge ClkBx);
                confCtl = '0;
            end
            "D": begin
                confCtl.defConf = 1'b1;
                @(negedge ClkBx);
                confCtl = '0;
            end
            "R": begin
                resetBcid = 1'b1;
                @(negedge ClkBx);
                resetBcid = 1'b0;
            end
            "H": begin
                hits[cmdA[i]] = `MP_COLS'(cmdB[i]);
                @(negedge ClkBx);
                hits = '0;
            end
            "P": begin
                pulse = 1'b1;
                @(negedge ClkBx);
                pulse = 1'b0;
            end
            "I": repeat (cmdA[i]) @(negedge ClkBx);
            "E": begin
                quiet = 0;
                while (quiet < 4) begin   // Bus idle for a few cycles
                    @(negedge ClkBx);
                    quiet = busReq.cyc ? 0 : quiet + 1;
                end
                sectionDone = 1'b1;
                @(negedge ClkBx);
                sectionDone = 1'b0;
                tests++;
            end
            default: ;
        endcase
    endtask

    initial begin
        reset_ff    = 1'b1;
        confCtl     = '0;
        resetBcid   = 1'b0;
        hits        = '0;
        pulse       = 1'b0;
        busAck      = 1'b0;
        sectionDone = 1'b0;
        sectionName = '0;
        lfsr        = 32'hd24278c7;
        cycles      = 0;
        tests       = 0;
        ackWait     = -1;
        limit       = 100000;
        readTrace();
        repeat (16) @(negedge ClkBx);
        reset_ff = 1'b0;
        foreach (cmdOp[i]) begin
            runCommand(i);
        end
        $display("Tests run: %0d, words checked: %0d, errors: %0d, assertion failures: %0d",
                 tests, words, errors,
                 u_monopixPeriphery.u_readoutArbiter.u_arbiterAsserts.failures);
        if (tests > 0 && errors == 0
                && u_monopixPeriphery.u_readoutArbiter.u_arbiterAsserts.failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* monopix_params.svh */
`ifndef MONOPIX_PARAMS_SVH
`define MONOPIX_PARAMS_SVH

// Readout geometry
`define MP_FLAVORS 4
`define MP_COLS 4

// Gray stamp width with the counter wrapping at 64
`define MP_BCID_BITS 6

// Default image for the configuration chain
`define MP_DEF_EN_FLAVOR 4'hF   // All flavours read out
`define MP_DEF_EN_HITOR 4'h0    // Hit-OR outputs quiet

`endif

/* readoutArbiter.sv */
`timescale 1ns/10ps

module readoutArbiter import monopixPkg::*; #(
    parameter type PayloadT   = tHitWord,
    parameter int  NumMasters = 4
) (ClkBx, reset_ff, reqIn, ackOut, reqOut, ackIn);

    typedef struct packed {
        logic    cyc;
        logic    stb;
        PayloadT dat;
    } tReq;

    localparam int IdxW = (NumMasters > 1) ? $clog2(NumMasters) : 1;

    input  logic                  ClkBx;
    input  logic                  reset_ff;
    input  tReq [NumMasters-1:0]  reqIn;
    output logic [NumMasters-1:0] ackOut;
    output tReq                   reqOut;
    input  logic                  ackIn;

    logic [IdxW-1:0]       lastServed;
    logic [IdxW-1:0]       lockIdx;
    logic                  locked;      // Grant held until ack
    logic [IdxW-1:0]       pick;
    logic                  pickValid;
    logic [IdxW-1:0]       grantIdx;
    logic                  grantValid;
    logic [NumMasters-1:0] grantOh;

    // Nearest requester after the last served one
    always_comb begin
        int cand;
        pick      = lastServed;
        pickValid = 1'b0;
        for (int off = NumMasters; off >= 1; off--) begin
            cand = (int'(lastServed) + off) % NumMasters;
            if (reqIn[cand].cyc && reqIn[cand].stb) begin
                pick      = IdxW'(cand);
                pickValid = 1'b1;
            end
        end
    end

    assign grantIdx   = locked ? lockIdx : pick;
    assign grantValid = locked | pickValid;

    always_comb begin
        grantOh = '0;
        if (grantValid) begin
            grantOh[grantIdx] = 1'b1;
        end
    end

    assign ackOut = grantOh & {NumMasters{ackIn}};
    assign reqOut = grantValid ? reqIn[grantIdx] : '0;   // Straight through without a register

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            lastServed <= IdxW'(NumMasters - 1);   // Master 0 goes first
            lockIdx    <= '0;
            locked     <= 1'b0;
        end else if (grantValid && ackIn) begin
            lastServed <= grantIdx;
            locked     <= 1'b0;
        end else if (pickValid && !locked) begin
            lockIdx <= pick;
            locked  <= 1'b1;
        end
    end

endmodule

/* readoutTrace.txt */
# Command letter, then hex arguments; I counts idle cycles in hex
# T name | C word | L | D | R | H flavour mask | P | I cycles | E
T defaults
H 0 5
I c
H 2 8
I c
C a5c3f0
C 3c5a96
I 2
E
T bcidStamp
R
I 5
H 1 1
I 14
H 3 2
I 3c
H 0 4
I c
E
T multiCol
H 2 f
H 0 b
H 1 6
H 3 9
I 28
E
T disable
C 700000
L
H 3 f
H 1 3
I 14
E
T pulseInj
C f03a51
L
P
I 1e
E
T hitOr
C ff00f0
L
H 2 1
P
H 3 c
I 1e
E
